// File: source/core_pkg.sv
package core_pkg;

  // --------------------------------------------------
  // Architectural widths
  // --------------------------------------------------
  localparam int XLEN       = 32;              // Data path width
  localparam int REG_ADDR_W = 5;               // GPR address width
  localparam int OPR_SRC_W  = 8;               // Operand source byte width

  // --------------------------------------------------
  // Operand source byte bit positions
  // --------------------------------------------------
  // Bits 4 to 7 are reserved and never looked at
  localparam int OPR_A_RS1 = 0;                // Operand A from rs1
  localparam int OPR_A_PC  = 1;                // Operand A from PC
  localparam int OPR_B_RS2 = 2;                // Operand B from rs2
  localparam int OPR_B_IMM = 3;                // Operand B from immediate

  // --------------------------------------------------
  // ALU micro-ops
  // --------------------------------------------------
  typedef enum logic [3:0] {
    UOP_ADD  = 4'd0,                           // a + b
    UOP_SUB  = 4'd1,                           // a - b
    UOP_AND  = 4'd2,                           // Bitwise and
    UOP_OR   = 4'd3,                           // Bitwise or
    UOP_XOR  = 4'd4,                           // Bitwise xor
    UOP_SLL  = 4'd5,                           // Shift left logical
    UOP_SRL  = 4'd6,                           // Shift right logical
    UOP_SRA  = 4'd7,                           // Shift right arithmetic
    UOP_SLT  = 4'd8,                           // Signed compare
    UOP_SLTU = 4'd9,                           // Unsigned compare
    UOP_LUI  = 4'd10                           // Pass operand B
  } uop_t;

endpackage

// File: source/pipe_pkg.sv
package pipe_pkg;

  import core_pkg::*;

  // --------------------------------------------------
  // Stage 2 decoded instruction into dispatch
  // --------------------------------------------------
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;                 // Destination register
    logic [REG_ADDR_W-1:0] rs1;                // Source register 1
    logic [REG_ADDR_W-1:0] rs2;                // Source register 2
    logic [XLEN-1:0]       imm;                // Decoded immediate
    logic [XLEN-1:0]       pc;                 // Program counter
    uop_t                  uop;                // Micro-op
    logic                  trap;               // Raise a trap
    logic [OPR_SRC_W-1:0]  opr_src;            // Operand sources
    logic [31:0]           instr;              // Instruction word
  } s2_t;

  // --------------------------------------------------
  // Stage 3 gathered operands into execute
  // --------------------------------------------------
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       opr_a;              // Resolved operand A
    logic [XLEN-1:0]       opr_b;              // Resolved operand B
    logic [XLEN-1:0]       pc;
    uop_t                  uop;
    logic                  trap;
    logic [31:0]           instr;
  } s3_t;

  // Stage 4 result waiting to retire
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       wdata;              // ALU result
    logic [XLEN-1:0]       pc;
    logic                  trap;
    logic [31:0]           instr;
  } s4_t;

  typedef s4_t retire_t;                       // Same layout at the retire port

  // Forwarding bus from a later stage
  typedef struct packed {
    logic                  valid;              // Result may be forwarded
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       wdata;
  } fwd_t;

endpackage

// File: source/gpr_file.sv
module gpr_file
  import core_pkg::*;
#(
  parameter int XLEN_P = XLEN                  // Register width
) (
  input  logic                  g_clk,         // Global clock
  input  logic                  rst,           // Sync reset, active high
  input  logic [REG_ADDR_W-1:0] rs1_addr,      // Read port 1 address
  input  logic [REG_ADDR_W-1:0] rs2_addr,      // Read port 2 address
  output logic [XLEN_P-1:0]     rs1_data,      // Read port 1 data
  output logic [XLEN_P-1:0]     rs2_data,      // Read port 2 data
  input  logic                  wen,           // Write enable
  input  logic [REG_ADDR_W-1:0] rd,            // Write address
  input  logic [XLEN_P-1:0]     wdata          // Write data
);

  localparam int NREGS = 2 ** REG_ADDR_W;      // x0 included in the count

  logic [XLEN_P-1:0] regs [1:NREGS-1];         // Only x1 to x31 have storage

  // --------------------------------------------------
  // Asynchronous read ports
  // --------------------------------------------------
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr]; // x0 reads zero
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------
  always_ff @(posedge g_clk) begin
    if (rst) begin
      for (int i = 1; i < NREGS; i++) begin
        regs[i] <= '0;                         // Architectural state cleared
      end
    end else if (wen && rd != '0) begin        // x0 writes dropped
      regs[rd] <= wdata;
    end
  end

  // Retiring results must be fully defined
  a_wdata_known : assert property (
    @(posedge g_clk) disable iff (rst) wen |-> !$isunknown(wdata)
  ) else $error("gpr_file: write of unknown data to x%0d", rd);

endmodule

// File: source/pipeline_dispatch.sv
module pipeline_dispatch
  import core_pkg::*;
  import pipe_pkg::*;
(
  input  logic                  g_clk,         // Global clock
  input  logic                  rst,           // Sync reset, active high
  input  logic                  s2_p_valid,    // Stage 2 holds an instruction
  input  s2_t                   s2,            // Decoded instruction
  output logic                  s2_p_busy,     // Stage 2 must hold
  output logic [REG_ADDR_W-1:0] rs1_addr,      // GPR read address 1
  output logic [REG_ADDR_W-1:0] rs2_addr,      // GPR read address 2
  input  logic [XLEN-1:0]       rs1_data,      // GPR read data 1
  input  logic [XLEN-1:0]       rs2_data,      // GPR read data 2
  input  fwd_t                  fwd_s3,        // Result in execute
  input  fwd_t                  fwd_s4,        // Result in writeback
  output logic                  s3_p_valid,    // Stage 3 holds an instruction
  output s3_t                   s3,            // Stage 3 payload
  input  logic                  s3_p_busy      // Execute cannot take stage 3
);

  logic            s3_valid_q;                 // Stage 3 occupied
  s3_t             s3_q;                       // Stage 3 payload register
  s3_t             s3_d;                       // Next payload
  logic            accept;                     // Stage 2 hands over this cycle
  logic [XLEN-1:0] rs1_val;                    // rs1 after forwarding
  logic [XLEN-1:0] rs2_val;                    // rs2 after forwarding
  logic [XLEN-1:0] opr_a;
  logic [XLEN-1:0] opr_b;

  // Execute result before writeback before the register file
  function automatic logic [XLEN-1:0] resolve(
    input logic [REG_ADDR_W-1:0] addr,
    input logic [XLEN-1:0]       rf_data,
    input fwd_t                  f3,
    input fwd_t                  f4
  );
    if (addr == '0) begin
      return '0;                               // x0 never forwards
    end else if (f3.valid && f3.rd == addr) begin
      return f3.wdata;
    end else if (f4.valid && f4.rd == addr) begin
      return f4.wdata;
    end
    return rf_data;
  endfunction

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------
  assign s2_p_busy = s3_valid_q && s3_p_busy;  // Full and blocked downstream
  assign accept    = s2_p_valid && !s2_p_busy;

  // --------------------------------------------------
  // Operand gathering
  // --------------------------------------------------
  assign rs1_addr = s2.rs1;
  assign rs2_addr = s2.rs2;

  assign rs1_val = resolve(s2.rs1, rs1_data, fwd_s3, fwd_s4);
  assign rs2_val = resolve(s2.rs2, rs2_data, fwd_s3, fwd_s4);

  always_comb begin
    if (s2.opr_src[OPR_A_RS1]) begin
      opr_a = rs1_val;
    end else if (s2.opr_src[OPR_A_PC]) begin
      opr_a = s2.pc;                           // AUIPC style
    end else begin
      opr_a = '0;
    end
    if (s2.opr_src[OPR_B_RS2]) begin
      opr_b = rs2_val;
    end else if (s2.opr_src[OPR_B_IMM]) begin
      opr_b = s2.imm;
    end else begin
      opr_b = '0;
    end
  end

  always_comb begin
    s3_d       = '0;
    s3_d.rd    = s2.rd;
    s3_d.opr_a = opr_a;
    s3_d.opr_b = opr_b;
    s3_d.pc    = s2.pc;
    s3_d.uop   = s2.uop;
    s3_d.trap  = s2.trap;
    s3_d.instr = s2.instr;
  end

  // --------------------------------------------------
  // Stage 3 register
  // --------------------------------------------------
  always_ff @(posedge g_clk) begin
    if (rst) begin
      s3_valid_q <= 1'b0;
    end else if (accept) begin
      s3_valid_q <= 1'b1;
    end else if (!s3_p_busy) begin
      s3_valid_q <= 1'b0;                      // Handed on with nothing behind it
    end
  end

  always_ff @(posedge g_clk) begin
    if (accept) begin
      s3_q <= s3_d;
    end
  end

  assign s3_p_valid = s3_valid_q;
  assign s3         = s3_q;

  // Source keeps its word until it is taken
  a_s2_hold : assert property (
    @(posedge g_clk) disable iff (rst)
    s2_p_valid && s2_p_busy |=> s2_p_valid && $stable(s2)
  ) else $error("pipeline_dispatch: s2 changed while busy");

endmodule

// File: source/pipeline_execute.sv
module pipeline_execute
  import core_pkg::*;
  import pipe_pkg::*;
#(
  parameter int XLEN_P = XLEN                  // ALU width
) (
  input  logic    g_clk,                       // Global clock
  input  logic    rst,                         // Sync reset, active high
  input  logic    s3_p_valid,                  // Stage 3 holds an instruction
  input  s3_t     s3,                          // Stage 3 payload
  output logic    s3_p_busy,                   // Stage 4 cannot take more
  input  logic    retire_stall,                // Memory stall stand-in
  output fwd_t    fwd_s3,                      // Forward from ALU output
  output fwd_t    fwd_s4,                      // Forward from stage 4
  output logic    retire_valid,                // Instruction retires now
  output retire_t retire                       // Retired instruction
);

  logic [XLEN_P-1:0] opr_a;
  logic [XLEN_P-1:0] opr_b;
  logic [4:0]        shamt;                    // Low bits of operand B
  logic [XLEN_P-1:0] alu_res;
  logic              s4_load;                  // Stage 3 moves into stage 4
  logic              s4_valid_q;
  s4_t               s4_q;                     // Writeback payload

  assign opr_a = s3.opr_a;
  assign opr_b = s3.opr_b;
  assign shamt = opr_b[4:0];

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------
  always_comb begin
    case (s3.uop)
      UOP_ADD:  alu_res = opr_a + opr_b;
      UOP_SUB:  alu_res = opr_a - opr_b;
      UOP_AND:  alu_res = opr_a & opr_b;
      UOP_OR:   alu_res = opr_a | opr_b;
      UOP_XOR:  alu_res = opr_a ^ opr_b;
      UOP_SLL:  alu_res = opr_a << shamt;
      UOP_SRL:  alu_res = opr_a >> shamt;
      UOP_SRA:  alu_res = $signed(opr_a) >>> shamt;
      UOP_SLT:  alu_res = {{(XLEN_P-1){1'b0}}, $signed(opr_a) < $signed(opr_b)};
      UOP_SLTU: alu_res = {{(XLEN_P-1){1'b0}}, opr_a < opr_b};
      UOP_LUI:  alu_res = opr_b;               // Immediate already shifted
      default:  alu_res = '0;
    endcase
  end

  // --------------------------------------------------
  // Stage 4 writeback register
  // --------------------------------------------------
  assign s3_p_busy    = s4_valid_q && retire_stall;
  assign s4_load      = s3_p_valid && !s3_p_busy;
  assign retire_valid = s4_valid_q && !retire_stall;

  always_ff @(posedge g_clk) begin
    if (rst) begin
      s4_valid_q <= 1'b0;
    end else if (s4_load) begin
      s4_valid_q <= 1'b1;
    end else if (retire_valid) begin
      s4_valid_q <= 1'b0;                      // Drained with no new entry
    end
  end

  always_ff @(posedge g_clk) begin
    if (s4_load) begin
      s4_q <= '{rd: s3.rd, wdata: alu_res, pc: s3.pc, trap: s3.trap, instr: s3.instr};
    end
  end

  assign retire = s4_q;

  // Trapped results are never forwarded
  assign fwd_s3 = '{valid: s3_p_valid && !s3.trap, rd: s3.rd, wdata: alu_res};
  assign fwd_s4 = '{valid: s4_valid_q && !s4_q.trap, rd: s4_q.rd, wdata: s4_q.wdata};

  // Stalled entry must not move
  a_s4_hold : assert property (
    @(posedge g_clk) disable iff (rst)
    s4_valid_q && retire_stall |=> s4_valid_q && $stable(s4_q)
  ) else $error("pipeline_execute: stage 4 changed under stall");

endmodule

// File: source/pipeline_back.sv
module pipeline_back
  import core_pkg::*;
  import pipe_pkg::*;
#(
  parameter int XLEN_P = XLEN                  // Data path width
) (
  input  logic    g_clk,                       // Global clock
  input  logic    rst,                         // Sync reset, active high
  input  logic    s2_p_valid,                  // Decoded instruction present
  input  s2_t     s2,                          // Decoded instruction
  output logic    s2_p_busy,                   // Decode must hold
  input  logic    retire_stall,                // Memory stall stand-in
  output logic    retire_valid,                // Instruction retires
  output retire_t retire                       // Retired instruction
);

  // --------------------------------------------------
  // Dispatch to execute
  // --------------------------------------------------
  logic s3_p_valid;
  s3_t  s3;
  logic s3_p_busy;

  // --------------------------------------------------
  // Forwarding
  // --------------------------------------------------
  fwd_t fwd_s3;                                // From ALU output
  fwd_t fwd_s4;                                // From writeback register

  // --------------------------------------------------
  // Register file
  // --------------------------------------------------
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN_P-1:0]     rs1_data;
  logic [XLEN_P-1:0]     rs2_data;
  logic                  gpr_wen;

  assign gpr_wen = retire_valid && !retire.trap; // Traps leave state alone

  pipeline_dispatch i_pipeline_dispatch (
    .g_clk, .rst, .s2_p_valid, .s2, .s2_p_busy,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .fwd_s3, .fwd_s4, .s3_p_valid, .s3, .s3_p_busy
  );

  pipeline_execute #(.XLEN_P(XLEN_P)) i_pipeline_execute (
    .g_clk, .rst, .s3_p_valid, .s3, .s3_p_busy, .retire_stall,
    .fwd_s3, .fwd_s4, .retire_valid, .retire
  );

  gpr_file #(.XLEN_P(XLEN_P)) i_gpr_file (
    .g_clk, .rst, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .wen   (gpr_wen),
    .rd    (retire.rd),
    .wdata (retire.wdata)
  );

endmodule

// File: verif/tb_pipeline_back.sv
module tb_pipeline_back
  import core_pkg::*;
  import pipe_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_INSTR    = 400;
  localparam int N_DIRECTED = 44;               // 11 uops x 4 operand source pairs
  localparam int LIMIT      = N_INSTR * 4 + 100;

  logic    g_clk = 1'b0;
  logic    rst;
  logic    s2_p_valid;
  s2_t     s2;
  logic    s2_p_busy;
  logic    retire_stall;
  logic    retire_valid;
  retire_t retire;

  integer      seed = 32'h859e2e6e;
  logic [31:0] model_regs [0:31] = '{default: '0};
  retire_t     want_q [$];                      // Expected retires, in order
  int          acc_cyc_q [$];                   // Acceptance cycle of each
  logic        accepted = 1'b0;                 // Set at the accepting edge
  int          cycle = 0;
  int          last_stall = -1;                 // Last edge with stall high
  int          n_accepted = 0;
  int          n_retired = 0;
  int          errors = 0;

  pipeline_back UUT (
    .g_clk, .rst, .s2_p_valid, .s2, .s2_p_busy,
    .retire_stall, .retire_valid, .retire
  );

  always #4 g_clk = ~g_clk;

  task automatic report_mismatch(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
    errors++;
    $display("[FAIL] t=%0t %s expected 0x%h actual 0x%h", $time, name, want, got);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    errors++;
    $display("Error at t=%0t: %s", $time, why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  // Expected retire from the ALU rules and the model state
  function automatic retire_t ref_exec(input s2_t ins, input logic [31:0] regs [0:31]);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    retire_t     r;
    a = ins.opr_src[OPR_A_PC] ? ins.pc : regs[ins.rs1];   // regs[0] stays zero
    b = ins.opr_src[OPR_B_IMM] ? ins.imm : regs[ins.rs2];
    case (ins.uop)
      UOP_ADD:  res = a + b;
      UOP_SUB:  res = a - b;
      UOP_AND:  res = a & b;
      UOP_OR:   res = a | b;
      UOP_XOR:  res = a ^ b;
      UOP_SLL:  res = a << b[4:0];
      UOP_SRL:  res = a >> b[4:0];
      UOP_SRA:  res = $signed(a) >>> b[4:0];
      UOP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      UOP_SLTU: res = (a < b) ? 32'd1 : 32'd0;
      default:  res = b;                        // LUI
    endcase
    r = '{rd: ins.rd, wdata: res, pc: ins.pc, trap: ins.trap, instr: ins.instr};
    return r;
  endfunction

  // Directed sweep then random over x0 to x4 for dense hazards
  function automatic s2_t make_instr(input int n);
    s2_t  ins;
    logic a_pc;
    logic b_imm;
    ins         = '0;
    ins.rd      = 5'($unsigned($random(seed)) % 5);
    ins.rs1     = 5'($unsigned($random(seed)) % 5);
    ins.rs2     = 5'($unsigned($random(seed)) % 5);
    ins.imm     = $random(seed);
    ins.pc      = 32'(n * 4);                   // Unique tag for ordering
    ins.instr   = $random(seed);
    ins.opr_src = 8'($random(seed));            // Reserved upper bits random
    if (n < N_DIRECTED) begin
      ins.uop = uop_t'(n / 4);
      a_pc    = n[0];
      b_imm   = n[1];
      ins.trap = 1'b0;
    end else begin
      ins.uop  = uop_t'($unsigned($random(seed)) % 11);
      a_pc     = $random(seed);
      b_imm    = $random(seed);
      ins.trap = (($random(seed) & 15) == 0);   // 1 in 16
    end
    ins.opr_src[OPR_A_RS1] = !a_pc;
    ins.opr_src[OPR_A_PC]  = a_pc;
    ins.opr_src[OPR_B_RS2] = !b_imm;
    ins.opr_src[OPR_B_IMM] = b_imm;
    return ins;
  endfunction

  task automatic drive_stall(input int n);
    retire_stall = (n >= N_DIRECTED) && (($random(seed) % 3) == 0);
  endtask

  // --------------------------------------------------
  // Driver on the falling edge
  // --------------------------------------------------
  initial begin
    retire_t want;
    rst          = 1'b1;
    s2_p_valid   = 1'b0;
    s2           = '0;
    retire_stall = 1'b0;
    repeat (5) @(negedge g_clk);
    rst = 1'b0;
    assert (!s2_p_busy && !retire_valid)
      else abort_run("s2_p_busy or retire_valid high right after reset");
    for (int n = 0; n < N_INSTR; n++) begin
      s2         = make_instr(n);
      s2_p_valid = 1'b1;
      drive_stall(n);
      @(negedge g_clk);
      while (!accepted) begin                   // Hold s2 while busy
        drive_stall(n);
        @(negedge g_clk);
      end
      accepted = 1'b0;
      want = ref_exec(s2, model_regs);
      if (!want.trap && want.rd != '0) begin
        model_regs[want.rd] = want.wdata;       // Traps and x0 writes dropped
      end
      want_q.push_back(want);
    end
    s2_p_valid   = 1'b0;
    retire_stall = 1'b0;
    while (want_q.size() != 0) @(negedge g_clk);
    repeat (4) @(negedge g_clk);                // Catch late duplicates
    if (errors == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1);
    end
  end

  // --------------------------------------------------
  // Checker and timeout on the rising edge
  // --------------------------------------------------
  always @(posedge g_clk) begin
    retire_t want;
    int      acc_cyc;
    logic    busy_exp;
    cycle++;
    if (cycle > LIMIT) abort_run("run did not finish within the cycle limit");
    if (retire_stall) last_stall = cycle;
    busy_exp = retire_stall && (n_accepted - n_retired == 2); // Stages 3 and 4 both full
    if (!rst) begin
      assert (s2_p_busy == busy_exp)
        else report_mismatch("s2_p_busy", busy_exp, s2_p_busy);
    end
    if (!rst && s2_p_valid && !s2_p_busy) begin
      accepted = 1'b1;
      acc_cyc_q.push_back(cycle);
      n_accepted++;
    end
    if (!rst && retire_valid) begin
      if (want_q.size() == 0) begin
        abort_run("retire_valid with no instruction outstanding");
      end else begin
        want    = want_q.pop_front();
        acc_cyc = acc_cyc_q.pop_front();
        n_retired++;
        assert (retire.pc == want.pc) else report_mismatch("retire.pc", want.pc, retire.pc);
        assert (retire.rd == want.rd) else report_mismatch("retire.rd", want.rd, retire.rd);
        assert (retire.trap == want.trap)
          else report_mismatch("retire.trap", want.trap, retire.trap);
        assert (retire.instr == want.instr)
          else report_mismatch("retire.instr", want.instr, retire.instr);
        assert (retire.wdata == want.wdata)
          else report_mismatch("retire.wdata", want.wdata, retire.wdata);
        if (last_stall <= acc_cyc) begin        // No stall since acceptance
          assert (cycle - acc_cyc == 2)
            else report_mismatch("retire latency", 2, cycle - acc_cyc);
        end
      end
    end
  end

endmodule

// File: verilog.f
source/core_pkg.sv
source/pipe_pkg.sv
source/gpr_file.sv
source/pipeline_dispatch.sv
source/pipeline_execute.sv
source/pipeline_back.sv
verif/tb_pipeline_back.sv
